// File: verilog/tag_engine_settings.svh
/* Tag engine sizes */
`ifndef TAG_ENGINE_SETTINGS_SVH
`define TAG_ENGINE_SETTINGS_SVH

// Number of tags in the free list, must be greater than one
`define NUM_TAGS 4

// Number of parallel work lanes
`define NUM_LANES 2

// Queue depth of each lane and its initial credit count
`define LANE_CREDITS 2

// Width of a request data word
`define DATA_W 16

// Multiplier applied by every lane
`define SCALE 5

`endif

// File: verilog/tag_engine_pkg.sv
/* Tag engine shared types */
`default_nettype none

`include "tag_engine_settings.svh"

package tag_engine_pkg;

  // Tag number, wide enough to name every tag
  typedef logic [$clog2(`NUM_TAGS)-1:0] tag_t;

  // Lane number, kept at least one bit wide for a single lane
  typedef logic [((`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1)-1:0] lane_idx_t;

  // Data word carried by a request and by its result
  typedef logic [`DATA_W-1:0] data_t;

  // Credit count from zero up to the full queue depth
  typedef logic [$clog2(`LANE_CREDITS + 1)-1:0] credit_t;

  // Request as pushed into a lane
  typedef struct packed {
    tag_t  tag;
    data_t data;
  } lane_req_t;

  // Completion with the original data next to the scaled result
  typedef struct packed {
    tag_t  tag;
    data_t data;
    data_t result;
  } cpl_t;

endpackage

`default_nettype wire

// File: verilog/tag_freelist.sv
/* Tag free list */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_freelist
  import tag_engine_pkg::*;
(
  input  logic clk,
  input  logic rst,

  // Allocation side, a registered offer of one free tag
  output logic alloc_valid,
  output tag_t alloc_tag,
  input  logic alloc_take,

  // Deallocation side, one returned tag per cycle
  input  logic dealloc_valid,
  input  tag_t dealloc_tag
);

  // Free tags that are not sitting in the staging register
  logic [`NUM_TAGS-1:0] free_vec;
  logic [`NUM_TAGS-1:0] free_vec_next;

  // One-hot form of the returned tag
  logic [`NUM_TAGS-1:0] dealloc_set;

  // Lowest free tag in one-hot and binary form
  logic [`NUM_TAGS-1:0] pick_onehot;
  tag_t                 pick_tag;
  logic                 pick_valid;

  // Staging register accepts a new tag this cycle
  logic                 stage_load;

  always_comb begin
    dealloc_set = '0;
    if (dealloc_valid) begin
      dealloc_set[dealloc_tag] = 1'b1;
    end
  end

  // The pick looks only at the registered vector, so a tag freed this
  // cycle becomes visible to the encoder one cycle later
  assign pick_valid  = |free_vec;
  assign pick_onehot = free_vec & (~free_vec + 1'b1);

  // Scan from the top so the lowest set bit wins
  always_comb begin
    pick_tag = '0;
    for (int i = `NUM_TAGS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        pick_tag = tag_t'(i);
      end
    end
  end

  // Load whenever the staging slot is empty or is being drained
  assign stage_load = pick_valid && (!alloc_valid || alloc_take);

  // Returned tags are merged first and the staged one is removed after
  always_comb begin
    free_vec_next = free_vec | dealloc_set;
    if (stage_load) begin
      free_vec_next = free_vec_next & ~pick_onehot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free_vec <= '1;
    end else begin
      free_vec <= free_vec_next;
    end
  end

  // Valid bit of the staging register
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_valid <= 1'b0;
    end else if (!alloc_valid || alloc_take) begin
      alloc_valid <= pick_valid;
    end
  end

  // Tag held in the staging register
  always_ff @(posedge clk) begin
    if (stage_load) begin
      alloc_tag <= pick_tag;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tag_dispatch.sv
/* Request dispatcher */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_dispatch
  import tag_engine_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // External request
  input  logic                   req_valid,
  input  data_t                  req_data,
  output logic                   req_ready,

  // Tag offer from the free list
  input  logic                   alloc_valid,
  input  tag_t                   alloc_tag,
  output logic                   alloc_take,

  // Lane side with credit based flow control
  output logic [`NUM_LANES-1:0]  lane_push,
  output lane_req_t              lane_req,
  input  logic [`NUM_LANES-1:0]  credit_return
);

  // Credits left per lane, each one is a free queue slot
  credit_t [`NUM_LANES-1:0] credit_cnt;

  // Lane that gets first look at the next request
  lane_idx_t                rr_ptr;

  logic [`NUM_LANES-1:0]    has_credit;
  lane_idx_t                sel_lane;
  logic                     sel_found;
  logic                     xfer;

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      has_credit[i] = (credit_cnt[i] != '0);
    end
  end

  // First lane with credit, searching upward from the pointer
  always_comb begin
    int idx;
    sel_found = 1'b0;
    sel_lane  = rr_ptr;
    for (int k = 0; k < `NUM_LANES; k++) begin
      idx = (int'(rr_ptr) + k) % `NUM_LANES;
      if (!sel_found && has_credit[idx]) begin
        sel_found = 1'b1;
        sel_lane  = lane_idx_t'(idx);
      end
    end
  end

  // Ready needs both a staged tag and somewhere to send it
  assign req_ready  = alloc_valid && sel_found;
  assign xfer       = req_valid && req_ready;
  assign alloc_take = xfer;

  // The request goes out in the same cycle together with its tag
  assign lane_req.tag  = alloc_tag;
  assign lane_req.data = req_data;

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      lane_push[i] = xfer && (sel_lane == lane_idx_t'(i));
    end
  end

  // A return and a push in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_LANES; i++) begin
        credit_cnt[i] <= credit_t'(`LANE_CREDITS);
      end
    end else begin
      for (int i = 0; i < `NUM_LANES; i++) begin
        credit_cnt[i] <= credit_cnt[i] + credit_t'(credit_return[i])
                         - credit_t'(lane_push[i]);
      end
    end
  end

  // Move the pointer one past the lane just served
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (xfer) begin
      rr_ptr <= lane_idx_t'((int'(sel_lane) + 1) % `NUM_LANES);
    end
  end

endmodule

`default_nettype wire

// File: verilog/work_lane.sv
/* Scaling work lane */
`default_nettype none

`include "tag_engine_settings.svh"

module work_lane
  import tag_engine_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Push side, never refused because the dispatcher holds the credits
  input  logic      push,
  input  lane_req_t req,
  output logic      credit_return,

  // Completion toward the collector
  output logic      cpl_valid,
  output cpl_t      cpl,
  input  logic      cpl_ready
);

  localparam int PTR_W = (`LANE_CREDITS > 1) ? $clog2(`LANE_CREDITS) : 1;

  // Request queue, one slot per credit
  lane_req_t        q_mem [`LANE_CREDITS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          q_count;
  lane_req_t        q_head;
  logic             q_pop;

  // First pipeline stage with the scaled value
  logic             s1_valid;
  lane_req_t        s1_req;
  data_t            s1_result;

  // Stage free flags, looking downstream
  logic             s2_free;
  logic             s1_free;

  assign q_head = q_mem[rd_ptr];

  assign s2_free = !cpl_valid || cpl_ready;
  assign s1_free = !s1_valid || s2_free;

  // Leave the queue when the first stage can take the head
  assign q_pop         = (q_count != '0) && s1_free;
  assign credit_return = q_pop;

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == `LANE_CREDITS - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (int'(rd_ptr) == `LANE_CREDITS - 1) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + credit_t'(push) - credit_t'(q_pop);
    end
  end

  // Stage one scales the data and keeps the low bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (s1_free) begin
      s1_valid <= q_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      s1_req    <= q_head;
      s1_result <= data_t'(q_head.data * `SCALE);
    end
  end

  // Stage two builds the completion and holds it until accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      cpl_valid <= 1'b0;
    end else if (s2_free) begin
      cpl_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_free && s1_valid) begin
      cpl.tag    <= s1_req.tag;
      cpl.data   <= s1_req.data;
      cpl.result <= s1_result;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpl_collector.sv
/* Completion collector */
`default_nettype none

`include "tag_engine_settings.svh"

module cpl_collector
  import tag_engine_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,

  // Completions offered by the lanes
  input  logic      [`NUM_LANES-1:0]    lane_cpl_valid,
  input  cpl_t      [`NUM_LANES-1:0]    lane_cpl,
  output logic      [`NUM_LANES-1:0]    lane_cpl_ready,

  // Registered output with back-pressure
  output logic                          cpl_valid,
  output cpl_t                          cpl,
  input  logic                          cpl_ready,

  // Tag return toward the free list
  output logic                          dealloc_valid,
  output tag_t                          dealloc_tag
);

  // Lane checked first on the next grant
  lane_idx_t rr_ptr;

  lane_idx_t sel_lane;
  logic      sel_found;
  logic      out_free;
  logic      grant;

  // The output slot can refill when empty or when it drains this cycle
  assign out_free = !cpl_valid || cpl_ready;

  // First valid lane at or after the pointer
  always_comb begin
    int idx;
    sel_found = 1'b0;
    sel_lane  = rr_ptr;
    for (int k = 0; k < `NUM_LANES; k++) begin
      idx = (int'(rr_ptr) + k) % `NUM_LANES;
      if (!sel_found && lane_cpl_valid[idx]) begin
        sel_found = 1'b1;
        sel_lane  = lane_idx_t'(idx);
      end
    end
  end

  assign grant = out_free && sel_found;

  // Only the granted lane sees ready
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      lane_cpl_ready[i] = grant && (sel_lane == lane_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cpl_valid <= 1'b0;
    end else if (out_free) begin
      cpl_valid <= sel_found;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      cpl <= lane_cpl[sel_lane];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (grant) begin
      rr_ptr <= lane_idx_t'((int'(sel_lane) + 1) % `NUM_LANES);
    end
  end

  // The tag goes back in the cycle its completion is accepted
  assign dealloc_valid = cpl_valid && cpl_ready;
  assign dealloc_tag   = cpl.tag;

endmodule

`default_nettype wire

// File: verilog/tag_engine_top.sv
/* Tag engine top */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_engine_top
  import tag_engine_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  logic  req_valid,
  input  data_t req_data,
  output logic  req_ready,

  output logic  cpl_valid,
  output cpl_t  cpl,
  input  logic  cpl_ready
);

  // Free list handshake
  logic alloc_valid;
  tag_t alloc_tag;
  logic alloc_take;
  logic dealloc_valid;
  tag_t dealloc_tag;

  // Dispatcher to lanes
  logic [`NUM_LANES-1:0] lane_push;
  lane_req_t             lane_req;
  logic [`NUM_LANES-1:0] credit_return;

  // Lanes to collector
  logic [`NUM_LANES-1:0] lane_cpl_valid;
  cpl_t [`NUM_LANES-1:0] lane_cpl;
  logic [`NUM_LANES-1:0] lane_cpl_ready;

  tag_freelist u_freelist (
    .clk           (clk),
    .rst           (rst),
    .alloc_valid   (alloc_valid),
    .alloc_tag     (alloc_tag),
    .alloc_take    (alloc_take),
    .dealloc_valid (dealloc_valid),
    .dealloc_tag   (dealloc_tag)
  );

  tag_dispatch u_dispatch (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_data      (req_data),
    .req_ready     (req_ready),
    .alloc_valid   (alloc_valid),
    .alloc_tag     (alloc_tag),
    .alloc_take    (alloc_take),
    .lane_push     (lane_push),
    .lane_req      (lane_req),
    .credit_return (credit_return)
  );

  // All lanes share the request bus and differ only in their push bit
  for (genvar i = 0; i < `NUM_LANES; i++) begin : gen_lane
    work_lane u_lane (
      .clk           (clk),
      .rst           (rst),
      .push          (lane_push[i]),
      .req           (lane_req),
      .credit_return (credit_return[i]),
      .cpl_valid     (lane_cpl_valid[i]),
      .cpl           (lane_cpl[i]),
      .cpl_ready     (lane_cpl_ready[i])
    );
  end

  cpl_collector u_collector (
    .clk            (clk),
    .rst            (rst),
    .lane_cpl_valid (lane_cpl_valid),
    .lane_cpl       (lane_cpl),
    .lane_cpl_ready (lane_cpl_ready),
    .cpl_valid      (cpl_valid),
    .cpl            (cpl),
    .cpl_ready      (cpl_ready),
    .dealloc_valid  (dealloc_valid),
    .dealloc_tag    (dealloc_tag)
  );

endmodule

`default_nettype wire

// File: sim/tag_engine_assertions.sv
/* Tag engine assertions */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_engine_assertions
  import tag_engine_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc_valid,
  input  tag_t                     alloc_tag,
  input  logic                     alloc_take,
  input  logic                     dealloc_valid,
  input  tag_t                     dealloc_tag,
  input  credit_t [`NUM_LANES-1:0] credit_cnt,
  input  logic                     cpl_valid,
  input  cpl_t                     cpl,
  input  logic                     cpl_ready
);

  // Failure counts, one per property
  int fail_offer   = 0;
  int fail_dealloc = 0;
  int fail_credit  = 0;
  int fail_stable  = 0;
  int fail_total;

  // Tags currently held by accepted requests
  logic [`NUM_TAGS-1:0] out_vec;
  logic                 credit_over;

  assign fail_total = fail_offer + fail_dealloc + fail_credit + fail_stable;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_vec <= '0;
    end else begin
      if (dealloc_valid) begin
        out_vec[dealloc_tag] <= 1'b0;
      end
      if (alloc_take) begin
        out_vec[alloc_tag] <= 1'b1;
      end
    end
  end

  // Any lane above its queue depth
  always_comb begin
    credit_over = 1'b0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (credit_cnt[i] > credit_t'(`LANE_CREDITS)) begin
        credit_over = 1'b1;
      end
    end
  end

  offer_is_free: assert property (@(posedge clk) disable iff (rst)
    alloc_valid |-> !out_vec[alloc_tag])
  else begin
    $error("staged tag %0d is still held by a request", alloc_tag);
    fail_offer++;
  end

  dealloc_was_taken: assert property (@(posedge clk) disable iff (rst)
    dealloc_valid |-> out_vec[dealloc_tag])
  else begin
    $error("tag %0d returned without having been taken", dealloc_tag);
    fail_dealloc++;
  end

  credit_in_range: assert property (@(posedge clk) disable iff (rst)
    !credit_over)
  else begin
    $error("a lane credit counter went above its queue depth");
    fail_credit++;
  end

  // A stalled completion keeps its valid and its contents
  cpl_held: assert property (@(posedge clk) disable iff (rst)
    cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl))
  else begin
    $error("completion changed while stalled");
    fail_stable++;
  end

endmodule

`default_nettype wire

// File: sim/tag_engine_checker.sv
/* Completion scoreboard */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_engine_checker
  import tag_engine_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  logic                  req_ready,
  input  data_t                 req_data,
  input  data_t                 req_exp,
  input  tag_t                  req_tag,
  input  logic [`NUM_LANES-1:0] lane_push,
  input  logic                  cpl_valid,
  input  cpl_t                  cpl,
  input  logic                  cpl_ready,
  output int                    err_count,
  output int                    req_count,
  output int                    cpl_count,
  output logic [`NUM_TAGS-1:0]  tag_reused
);

  // Record of the request that holds each tag
  logic [`NUM_TAGS-1:0] busy;
  data_t                out_data [`NUM_TAGS];
  data_t                out_exp  [`NUM_TAGS];
  lane_idx_t            out_lane [`NUM_TAGS];
  int                   out_seq  [`NUM_TAGS];
  int                   tag_uses [`NUM_TAGS];

  // Pushes issued and completions retired per lane
  int                   lane_issued [`NUM_LANES];
  int                   lane_done   [`NUM_LANES];

  always @(posedge clk) begin
    tag_t      t;
    lane_idx_t lane;
    if (rst) begin
      busy      = '0;
      err_count = 0;
      req_count = 0;
      cpl_count = 0;
      for (int i = 0; i < `NUM_TAGS; i++) begin
        tag_uses[i] = 0;
      end
      for (int i = 0; i < `NUM_LANES; i++) begin
        lane_issued[i] = 0;
        lane_done[i]   = 0;
      end
    end else begin
      // Completions go first, a freed tag is never reissued in the same cycle
      if (cpl_valid && cpl_ready) begin
        t = cpl.tag;
        if (!busy[t]) begin
          $display("completion carries tag %0d, which no outstanding request holds", t);
          err_count++;
        end else begin
          if (cpl.data != out_data[t]) begin
            $display("[FAIL] cpl.data for tag %0h: got %h, expected %h",
                     t, cpl.data, out_data[t]);
            err_count++;
          end
          if (cpl.result != out_exp[t]) begin
            $display("[FAIL] cpl.result for tag %0h: got %h, expected %h",
                     t, cpl.result, out_exp[t]);
            err_count++;
          end
          // Within one lane the completions keep push order
          lane = out_lane[t];
          if (out_seq[t] != lane_done[lane]) begin
            $display("lane %0d completed its requests out of order", lane);
            err_count++;
          end
          lane_done[lane] = out_seq[t] + 1;
          busy[t]         = 1'b0;
        end
        cpl_count++;
      end

      if (req_valid && req_ready) begin
        t = req_tag;
        if (int'(t) >= `NUM_TAGS) begin
          $display("request got tag %0d, which is beyond the tag range", t);
          err_count++;
        end
        if (busy[t]) begin
          $display("tag %0d was handed out again while still outstanding", t);
          err_count++;
        end
        if ($countones(lane_push) != 1) begin
          $display("accepted request went to %0d lanes instead of one", $countones(lane_push));
          err_count++;
        end
        lane = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
          if (lane_push[i]) begin
            lane = lane_idx_t'(i);
          end
        end
        busy[t]      = 1'b1;
        out_data[t]  = req_data;
        out_exp[t]   = req_exp;
        out_lane[t]  = lane;
        out_seq[t]   = lane_issued[lane];
        lane_issued[lane]++;
        tag_uses[t]++;
        req_count++;
        if (req_count - cpl_count > `NUM_TAGS) begin
          $display("more than %0d requests are outstanding", `NUM_TAGS);
          err_count++;
        end
      end
    end

    // A tag counts as reused once two requests have held it
    for (int i = 0; i < `NUM_TAGS; i++) begin
      tag_reused[i] = (tag_uses[i] >= 2);
    end
  end

endmodule

`default_nettype wire

// File: sim/tag_engine_tb.sv
/* Tag engine testbench */
`default_nettype none

`include "tag_engine_settings.svh"

module tag_engine_tb
  import tag_engine_pkg::*;
();

  localparam int NUM_REQ         = 22;
  localparam int ROW_W           = $clog2(NUM_REQ);
  localparam int WATCHDOG_CYCLES = 60 * NUM_REQ + 200;

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  data_t                req_data;
  data_t                req_exp;
  logic                 req_ready;
  logic                 cpl_valid;
  cpl_t                 cpl;
  logic                 cpl_ready;

  // Each row packs data, idle cycles, stall cycles and expected result
  logic [63:0]          rows [NUM_REQ];

  int                   cycle       = 0;
  int                   stall_until = 0;
  int                   tb_errors;
  int                   chk_errors;
  int                   req_count;
  int                   cpl_count;
  logic [`NUM_TAGS-1:0] tag_reused;

  tag_engine_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_data  (req_data),
    .req_ready (req_ready),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .cpl_ready (cpl_ready)
  );

  tag_engine_checker checker0 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_data   (req_data),
    .req_exp    (req_exp),
    .req_tag    (dut0.alloc_tag),
    .lane_push  (dut0.lane_push),
    .cpl_valid  (cpl_valid),
    .cpl        (cpl),
    .cpl_ready  (cpl_ready),
    .err_count  (chk_errors),
    .req_count  (req_count),
    .cpl_count  (cpl_count),
    .tag_reused (tag_reused)
  );

  bind tag_engine_top tag_engine_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .alloc_valid   (alloc_valid),
    .alloc_tag     (alloc_tag),
    .alloc_take    (alloc_take),
    .dealloc_valid (dealloc_valid),
    .dealloc_tag   (dealloc_tag),
    .credit_cnt    (u_dispatch.credit_cnt),
    .cpl_valid     (cpl_valid),
    .cpl           (cpl),
    .cpl_ready     (cpl_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Output back-pressure from the stall window plus random one-cycle drops
  // The window is read at the edge, before the request loop moves it
  initial begin
    logic hold;
    void'($urandom(32'hc62c));
    cpl_ready = 1'b0;
    forever begin
      @(posedge clk);
      hold = (cycle < stall_until);
      #1;
      cpl_ready = !hold && (($urandom % 8) != 0);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  // Every expected column has to follow the scaling rule
  function automatic int count_bad_rows();
    int               bad;
    logic [ROW_W-1:0] r;
    data_t            want;
    bad = 0;
    for (int i = 0; i < NUM_REQ; i++) begin
      r    = ROW_W'(i);
      want = data_t'(rows[r][63:48] * `SCALE);
      if (rows[r][15:0] != want) begin
        $display("input row %0d has an expected result that is not data times %0d",
                 i, `SCALE);
        bad++;
      end
    end
    return bad;
  endfunction

  // Hold the request until the DUT takes it
  // The task starts and ends just after a rising edge
  task automatic send_request(input data_t data, input data_t exp);
    logic done;
    done      = 1'b0;
    req_valid = 1'b1;
    req_data  = data;
    req_exp   = exp;
    while (!done) begin
      @(negedge clk);
      done = req_ready;
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  initial begin
    logic [ROW_W-1:0] r;
    int               asr_errors;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_data  = '0;
    req_exp   = '0;
    tb_errors = 0;
    $readmemh("sim/tag_engine_input.txt", rows);
    tb_errors += count_bad_rows();

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NUM_REQ; i++) begin
      r = ROW_W'(i);
      repeat (int'(rows[r][47:32])) begin
        @(posedge clk);
        #1;
      end
      send_request(rows[r][63:48], rows[r][15:0]);
      // Stall the output from here on while later requests keep arriving
      if (cycle + int'(rows[r][31:16]) > stall_until) begin
        stall_until = cycle + int'(rows[r][31:16]);
      end
    end

    // Drain and give the free list time to restage a tag
    while (cpl_count < NUM_REQ) begin
      @(posedge clk);
      #1;
    end
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    if (!req_ready) begin
      $display("[FAIL] req_ready: got %h, expected %h", req_ready, 1'b1);
      tb_errors++;
    end
    if (req_count != NUM_REQ) begin
      $display("[FAIL] req_count: got %h, expected %h", req_count, NUM_REQ);
      tb_errors++;
    end
    if (cpl_count != req_count) begin
      $display("[FAIL] cpl_count: got %h, expected %h", cpl_count, req_count);
      tb_errors++;
    end
    if (tag_reused != '1) begin
      $display("[FAIL] tag_reused: got %h, expected %h", tag_reused, {`NUM_TAGS{1'b1}});
      tb_errors++;
    end

    asr_errors = dut0.u_assertions.fail_total;
    $display("errors: checker %0d, assertions %0d, testbench %0d",
             chk_errors, asr_errors, tb_errors);
    if (chk_errors + asr_errors + tb_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/tag_engine_pkg.sv
verilog/tag_freelist.sv
verilog/tag_dispatch.sv
verilog/work_lane.sv
verilog/cpl_collector.sv
verilog/tag_engine_top.sv
sim/tag_engine_assertions.sv
sim/tag_engine_checker.sv
sim/tag_engine_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the tag engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tag_engine_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtag_engine_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

// File: sim/tag_engine_input.txt
// One request per line as data_idle_stall_expected, all fields in hex
// Idle cycles come before the request, output stall cycles follow it
0001_0000_0000_0005
1234_0000_0000_5b04
ffff_0002_0000_fffb
0000_0001_0000_0000
3333_0000_0000_ffff
abcd_0003_0000_5b01
0100_0010_0030_0500
0200_0000_0000_0a00
0300_0000_0000_0f00
0400_0000_0000_1400
0500_0000_0000_1900
7fff_0000_0000_7ffb
8000_0004_0000_8000
0f0f_0000_0002_4b4b
cafe_0002_0000_f6f6
00ff_0014_0028_04fb
0a0a_0000_0000_3232
1111_0000_0000_5555
2222_0000_0000_aaaa
3030_0000_0000_f0f0
9999_0001_0000_fffd
4444_0000_0003_5554
